// File: logic/qmm_params.svh
`ifndef QMM_PARAMS_SVH
`define QMM_PARAMS_SVH

// Array geometry
`define QMM_LANES 4
`define QMM_ROWS 4
`define QMM_SUBS 2

// Bus and index widths
`define QMM_DW (`QMM_LANES * 8)
`define QMM_AW 12
`define QMM_RAW ($clog2(`QMM_ROWS))
`define QMM_SUBW ($clog2(`QMM_SUBS))
`define QMM_YW (`QMM_ROWS * 8)

// Parameter word fields from the top bits down
`define QMM_SCALE_W 16
`define QMM_ZX_W 8
`define QMM_ZW_W 4
`define QMM_ZO_W 4

`define QMM_SHIFT 12

`endif

// File: logic/qmm_pkg.sv
`default_nettype none

package qmm_pkg;

    // Command opcodes
    typedef enum logic {
        OP_FETCH = 1'b0,
        OP_EXEC  = 1'b1
    } qmm_op_e;

    // Parameter block fetch sequencing
    typedef enum logic [1:0] {
        F_IDLE,
        F_PARAM,   // Reading the quantization word
        F_ROWS,    // Reading weight rows
        F_FINISH   // Done pulse cycle
    } fetch_state_e;

    // Executor sequencing
    typedef enum logic [1:0] {
        E_IDLE,
        E_RUN,     // Issuing row addresses
        E_DRAIN    // Waiting for the last row to leave the pipe
    } exec_state_e;

endpackage

`default_nettype wire

// File: logic/qmm_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "qmm_params.svh"

module qmm_fetch (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire                      i_cmd_valid,
    input  wire qmm_pkg::qmm_op_e    i_cmd_op,
    input  wire [`QMM_SUBW-1:0]      i_cmd_sub,
    input  wire [`QMM_AW-1:0]        i_cmd_addr,
    input  wire [`QMM_DW-1:0]        i_wb_dat,
    input  wire                      i_wb_ack,
    output logic                     o_wb_cyc,
    output logic                     o_wb_stb,
    output logic [`QMM_AW-1:0]       o_wb_adr,
    output logic                     o_q_we,
    output logic [`QMM_DW-1:0]       o_q_word,
    output logic                     o_w_we,
    output logic [`QMM_RAW-1:0]      o_w_addr,
    output logic [`QMM_DW-1:0]       o_w_data,
    output logic [`QMM_SUBW-1:0]     o_wr_sub,
    output logic                     o_fetch_done
);

    import qmm_pkg::*;

    localparam logic [`QMM_RAW-1:0] LAST_ROW = `QMM_RAW'(`QMM_ROWS - 1);

    fetch_state_e        state;
    logic [`QMM_RAW-1:0] row;       // Row index of the read in flight
    logic                rd_ack;    // Read completes on this edge

    assign rd_ack       = o_wb_stb && i_wb_ack;
    assign o_fetch_done = (state == F_FINISH);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state    <= F_IDLE;
            row      <= '0;
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            o_wb_adr <= '0;
            o_q_we   <= 1'b0;
            o_w_we   <= 1'b0;
            o_wr_sub <= '0;
        end else begin
            o_q_we <= 1'b0;
            o_w_we <= 1'b0;
            case (state)
                F_IDLE: begin
                    if (i_cmd_valid && i_cmd_op == OP_FETCH) begin
                        o_wr_sub <= i_cmd_sub;
                        o_wb_adr <= i_cmd_addr;    // First word is the parameter word
                        o_wb_cyc <= 1'b1;
                        o_wb_stb <= 1'b1;
                        row      <= '0;
                        state    <= F_PARAM;
                    end
                end
                F_PARAM: begin
                    if (rd_ack) begin
                        o_q_we   <= 1'b1;
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_adr <= o_wb_adr + 1'b1;
                        state    <= F_ROWS;
                    end
                end
                F_ROWS: begin
                    if (!o_wb_stb) begin
                        o_wb_cyc <= 1'b1;          // Gap cycle over
                        o_wb_stb <= 1'b1;
                    end else if (rd_ack) begin
                        o_w_we   <= 1'b1;
                        o_wb_cyc <= 1'b0;
                        o_wb_stb <= 1'b0;
                        o_wb_adr <= o_wb_adr + 1'b1;
                        row      <= row + 1'b1;
                        if (row == LAST_ROW) begin
                            state <= F_FINISH;
                        end
                    end
                end
                F_FINISH: state <= F_IDLE;
                default:  state <= F_IDLE;
            endcase
        end
    end

    // Data taken on the ack edge and steered by the current phase
    always_ff @(posedge clk) begin
        if (rd_ack) begin
            if (state == F_PARAM) begin
                o_q_word <= i_wb_dat;
            end else begin
                o_w_addr <= row;
                o_w_data <= i_wb_dat;
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/qmm_weight_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "qmm_params.svh"

module qmm_weight_store (
    input  wire                              clk,
    input  wire                              i_w_we,
    input  wire [`QMM_SUBW-1:0]              i_wr_sub,
    input  wire [`QMM_RAW-1:0]               i_w_addr,
    input  wire [`QMM_DW-1:0]                i_w_data,
    input  wire [`QMM_SUBS*`QMM_RAW-1:0]     i_rd_addr,
    output logic [`QMM_SUBS*`QMM_DW-1:0]     o_rd_data
);

    for (genvar s = 0; s < `QMM_SUBS; s++) begin : g_bank
        localparam logic [`QMM_SUBW-1:0] BANK_ID = `QMM_SUBW'(s);

        logic [`QMM_DW-1:0] mem [`QMM_ROWS];
        logic [`QMM_DW-1:0] rd_q;

        always_ff @(posedge clk) begin
            if (i_w_we && i_wr_sub == BANK_ID) begin
                mem[i_w_addr] <= i_w_data;
            end
            rd_q <= mem[i_rd_addr[s*`QMM_RAW +: `QMM_RAW]];   // One cycle read latency
        end

        assign o_rd_data[s*`QMM_DW +: `QMM_DW] = rd_q;
    end

endmodule

`default_nettype wire

// File: logic/qmm_operand_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "qmm_params.svh"

module qmm_operand_regs (
    input  wire                                  clk,
    input  wire                                  rst_n,
    input  wire                                  i_q_we,
    input  wire [`QMM_SUBW-1:0]                  i_wr_sub,
    input  wire [`QMM_DW-1:0]                    i_q_word,
    input  wire [`QMM_SUBS-1:0]                  i_x_we,
    input  wire [`QMM_DW-1:0]                    i_x_data,
    output logic [`QMM_SUBS*`QMM_SCALE_W-1:0]    o_scale,
    output logic [`QMM_SUBS*`QMM_ZX_W-1:0]       o_zx,
    output logic [`QMM_SUBS*`QMM_ZW_W-1:0]       o_zw,
    output logic [`QMM_SUBS*`QMM_ZO_W-1:0]       o_zo,
    output logic [`QMM_SUBS*`QMM_DW-1:0]         o_x
);

    localparam int ZO_LSB = 0;
    localparam int ZW_LSB = ZO_LSB + `QMM_ZO_W;
    localparam int ZX_LSB = ZW_LSB + `QMM_ZW_W;
    localparam int SC_LSB = ZX_LSB + `QMM_ZX_W;

    for (genvar s = 0; s < `QMM_SUBS; s++) begin : g_sub
        localparam logic [`QMM_SUBW-1:0] SUB_ID = `QMM_SUBW'(s);

        logic [`QMM_SCALE_W-1:0] scale_q;
        logic [`QMM_ZX_W-1:0]    zx_q;
        logic [`QMM_ZW_W-1:0]    zw_q;
        logic [`QMM_ZO_W-1:0]    zo_q;
        logic [`QMM_DW-1:0]      x_q;

        always_ff @(posedge clk, negedge rst_n) begin
            if (!rst_n) begin
                scale_q <= '0;
                zx_q    <= '0;
                zw_q    <= '0;
                zo_q    <= '0;
                x_q     <= '0;
            end else begin
                if (i_q_we && i_wr_sub == SUB_ID) begin
                    scale_q <= i_q_word[SC_LSB +: `QMM_SCALE_W];
                    zx_q    <= i_q_word[ZX_LSB +: `QMM_ZX_W];
                    zw_q    <= i_q_word[ZW_LSB +: `QMM_ZW_W];
                    zo_q    <= i_q_word[ZO_LSB +: `QMM_ZO_W];
                end
                if (i_x_we[s]) begin
                    x_q <= i_x_data;
                end
            end
        end

        assign o_scale[s*`QMM_SCALE_W +: `QMM_SCALE_W] = scale_q;
        assign o_zx[s*`QMM_ZX_W +: `QMM_ZX_W]          = zx_q;
        assign o_zw[s*`QMM_ZW_W +: `QMM_ZW_W]          = zw_q;
        assign o_zo[s*`QMM_ZO_W +: `QMM_ZO_W]          = zo_q;
        assign o_x[s*`QMM_DW +: `QMM_DW]               = x_q;
    end

endmodule

`default_nettype wire

// File: logic/qmm_exec.sv
`timescale 1ns/100ps
`default_nettype none

`include "qmm_params.svh"

module qmm_exec #(
    parameter int SUB_ID = 0
) (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        i_cmd_valid,
    input  wire qmm_pkg::qmm_op_e      i_cmd_op,
    input  wire [`QMM_SUBW-1:0]        i_cmd_sub,
    input  wire [`QMM_DW-1:0]          i_x,
    input  wire [`QMM_SCALE_W-1:0]     i_scale,
    input  wire [`QMM_ZX_W-1:0]        i_zx,
    input  wire [`QMM_ZW_W-1:0]        i_zw,
    input  wire [`QMM_ZO_W-1:0]        i_zo,
    input  wire [`QMM_DW-1:0]          i_w_row,
    output logic [`QMM_RAW-1:0]        o_w_addr,
    output logic [`QMM_YW-1:0]         o_y_data,
    output logic                       o_exec_done
);

    import qmm_pkg::*;

    localparam logic [`QMM_SUBW-1:0] MY_SUB   = `QMM_SUBW'(SUB_ID);
    localparam logic [`QMM_RAW-1:0]  LAST_ROW = `QMM_RAW'(`QMM_ROWS - 1);
    localparam int OPW  = 9;                              // Zero-corrected int8
    localparam int SUMW = 2 * OPW + $clog2(`QMM_LANES);   // Row sum
    localparam int MULW = SUMW + `QMM_SCALE_W + 1;        // Row sum times scale

    exec_state_e             state;
    logic                    start;
    logic                    d_vld;   // Weight row valid at the store output
    logic                    s_vld;   // Row sum valid in sum_q
    logic [`QMM_RAW-1:0]     d_row;
    logic [`QMM_RAW-1:0]     s_row;
    logic signed [SUMW-1:0]  dot;
    logic signed [SUMW-1:0]  sum_q;
    logic [7:0]              y_byte;

    assign start = i_cmd_valid && i_cmd_op == OP_EXEC && i_cmd_sub == MY_SUB;

    // Signed dot product of one row against the vector
    always_comb begin
        logic signed [OPW-1:0]   xd;
        logic signed [OPW-1:0]   wd;
        logic signed [2*OPW-1:0] prod;
        dot = '0;
        for (int l = 0; l < `QMM_LANES; l++) begin
            xd   = $signed(i_x[l*8 +: 8]) - $signed(i_zx);
            wd   = $signed(i_w_row[l*8 +: 8]) - $signed(i_zw);
            prod = xd * wd;
            dot  = dot + prod;
        end
    end

    // Requantize to an unsigned byte
    always_comb begin
        logic signed [MULW-1:0] scaled;
        logic signed [MULW-1:0] biased;
        scaled = sum_q * $signed({1'b0, i_scale});
        biased = (scaled >>> `QMM_SHIFT) + $signed({1'b0, i_zo});
        if (biased < 0) begin
            y_byte = 8'd0;
        end else if (biased > 255) begin
            y_byte = 8'd255;
        end else begin
            y_byte = biased[7:0];
        end
    end

    always_ff @(posedge clk) begin
        sum_q <= dot;
    end

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state       <= E_IDLE;
            o_w_addr    <= '0;
            d_vld       <= 1'b0;
            s_vld       <= 1'b0;
            d_row       <= '0;
            s_row       <= '0;
            o_exec_done <= 1'b0;
            o_y_data    <= '0;
        end else begin
            d_vld       <= (state == E_RUN);   // Store answers one cycle later
            d_row       <= o_w_addr;
            s_vld       <= d_vld;
            s_row       <= d_row;
            o_exec_done <= 1'b0;
            if (s_vld) begin
                o_y_data[s_row*8 +: 8] <= y_byte;
            end
            case (state)
                E_IDLE: begin
                    if (start) begin
                        o_w_addr <= '0;
                        state    <= E_RUN;
                    end
                end
                E_RUN: begin
                    if (o_w_addr == LAST_ROW) begin
                        state <= E_DRAIN;
                    end else begin
                        o_w_addr <= o_w_addr + 1'b1;
                    end
                end
                E_DRAIN: begin
                    if (s_vld && s_row == LAST_ROW) begin
                        o_exec_done <= 1'b1;           // Same edge as the last byte
                        state       <= E_IDLE;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: logic/qmm_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "qmm_params.svh"

module qmm_top (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             i_cmd_valid,
    input  wire qmm_pkg::qmm_op_e           i_cmd_op,
    input  wire [`QMM_SUBW-1:0]             i_cmd_sub,
    input  wire [`QMM_AW-1:0]               i_cmd_addr,
    input  wire [`QMM_SUBS-1:0]             i_x_we,
    input  wire [`QMM_DW-1:0]               i_x_data,
    input  wire [`QMM_DW-1:0]               i_wb_dat,
    input  wire                             i_wb_ack,
    output logic                            o_wb_cyc,
    output logic                            o_wb_stb,
    output logic [`QMM_AW-1:0]              o_wb_adr,
    output logic                            o_fetch_done,
    output logic [`QMM_SUBS-1:0]            o_exec_done,
    output logic [`QMM_SUBS*`QMM_YW-1:0]    o_y_data
);

    logic                               q_we;
    logic [`QMM_DW-1:0]                 q_word;
    logic                               w_we;
    logic [`QMM_RAW-1:0]                w_addr;
    logic [`QMM_DW-1:0]                 w_data;
    logic [`QMM_SUBW-1:0]               wr_sub;
    logic [`QMM_SUBS*`QMM_RAW-1:0]      rd_addr;
    logic [`QMM_SUBS*`QMM_DW-1:0]       rd_data;
    logic [`QMM_SUBS*`QMM_SCALE_W-1:0]  scale;
    logic [`QMM_SUBS*`QMM_ZX_W-1:0]     zx;
    logic [`QMM_SUBS*`QMM_ZW_W-1:0]     zw;
    logic [`QMM_SUBS*`QMM_ZO_W-1:0]     zo;
    logic [`QMM_SUBS*`QMM_DW-1:0]       x;

    qmm_fetch u_fetch (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_sub    (i_cmd_sub),
        .i_cmd_addr   (i_cmd_addr),
        .i_wb_dat     (i_wb_dat),
        .i_wb_ack     (i_wb_ack),
        .o_wb_cyc     (o_wb_cyc),
        .o_wb_stb     (o_wb_stb),
        .o_wb_adr     (o_wb_adr),
        .o_q_we       (q_we),
        .o_q_word     (q_word),
        .o_w_we       (w_we),
        .o_w_addr     (w_addr),
        .o_w_data     (w_data),
        .o_wr_sub     (wr_sub),
        .o_fetch_done (o_fetch_done)
    );

    qmm_weight_store u_wstore (
        .clk       (clk),
        .i_w_we    (w_we),
        .i_wr_sub  (wr_sub),
        .i_w_addr  (w_addr),
        .i_w_data  (w_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    qmm_operand_regs u_oregs (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_q_we   (q_we),
        .i_wr_sub (wr_sub),
        .i_q_word (q_word),
        .i_x_we   (i_x_we),
        .i_x_data (i_x_data),
        .o_scale  (scale),
        .o_zx     (zx),
        .o_zw     (zw),
        .o_zo     (zo),
        .o_x      (x)
    );

    for (genvar s = 0; s < `QMM_SUBS; s++) begin : g_exec
        qmm_exec #(.SUB_ID(s)) u_exec (
            .clk         (clk),
            .rst_n       (rst_n),
            .i_cmd_valid (i_cmd_valid),
            .i_cmd_op    (i_cmd_op),
            .i_cmd_sub   (i_cmd_sub),
            .i_x         (x[s*`QMM_DW +: `QMM_DW]),
            .i_scale     (scale[s*`QMM_SCALE_W +: `QMM_SCALE_W]),
            .i_zx        (zx[s*`QMM_ZX_W +: `QMM_ZX_W]),
            .i_zw        (zw[s*`QMM_ZW_W +: `QMM_ZW_W]),
            .i_zo        (zo[s*`QMM_ZO_W +: `QMM_ZO_W]),
            .i_w_row     (rd_data[s*`QMM_DW +: `QMM_DW]),
            .o_w_addr    (rd_addr[s*`QMM_RAW +: `QMM_RAW]),
            .o_y_data    (o_y_data[s*`QMM_YW +: `QMM_YW]),
            .o_exec_done (o_exec_done[s])
        );
    end

endmodule

`default_nettype wire

// File: bench/qmm_wb_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "qmm_params.svh"

module qmm_wb_mem (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  i_wb_cyc,
    input  wire                  i_wb_stb,
    input  wire [`QMM_AW-1:0]    i_wb_adr,
    output logic [`QMM_DW-1:0]   o_wb_dat,
    output logic                 o_wb_ack
);

    logic [`QMM_DW-1:0] mem [2**`QMM_AW];     // Loaded by the testbench
    logic [`QMM_AW-1:0] acc_log [64];         // Address of every completed read
    logic [5:0]         log_ptr;
    int                 acc_cnt;              // Completed reads since reset
    int                 stb_err;              // Requests dropped or moved before ack
    logic               req_open;             // Request seen, ack still owed
    logic [`QMM_AW-1:0] req_adr;
    int                 wait_q;

    always @(posedge clk, negedge rst_n) begin : p_slave
        int wait_left;
        if (!rst_n) begin
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
            log_ptr  <= '0;
            acc_cnt  <= 0;
            stb_err  <= 0;
            req_open <= 1'b0;
            req_adr  <= '0;
            wait_q   <= 0;
        end else begin
            o_wb_ack <= 1'b0;
            req_open <= 1'b0;
            if (req_open && (!i_wb_cyc || !i_wb_stb || i_wb_adr != req_adr)) begin
                stb_err <= stb_err + 1;
                $display("%0t Wishbone read of address %0h was dropped before its ack",
                         $time, req_adr);
            end
            // New or pending request that is not being acked right now
            if (i_wb_cyc && i_wb_stb && !o_wb_ack) begin
                wait_left = req_open ? wait_q : int'($urandom % 4);
                if (wait_left == 0) begin
                    o_wb_ack         <= 1'b1;
                    o_wb_dat         <= mem[i_wb_adr];
                    acc_log[log_ptr] <= i_wb_adr;
                    log_ptr          <= log_ptr + 1'b1;
                    acc_cnt          <= acc_cnt + 1;
                end else begin
                    wait_q   <= wait_left - 1;
                    req_open <= 1'b1;
                    req_adr  <= i_wb_adr;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/qmm_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "qmm_params.svh"

module qmm_tb;

    import qmm_pkg::*;

    localparam logic [31:0] SEED = 32'h0ff9_871a;
    localparam int RST_CYCLES = 16;
    localparam int FETCH_TMO  = 200;
    localparam int EXEC_TMO   = 40;
    localparam int LAT        = `QMM_ROWS + 2;    // Command edge to done
    localparam logic [`QMM_AW-1:0] BLK_A   = 12'h100;
    localparam logic [`QMM_AW-1:0] BLK_B   = 12'h240;
    localparam logic [`QMM_AW-1:0] BLK_C   = 12'h0a0;
    localparam logic [`QMM_AW-1:0] BLK_SAT = 12'h7fb;

    logic                          clk;
    logic                          rst_n;
    logic                          cmd_valid;
    qmm_op_e                       cmd_op;
    logic [`QMM_SUBW-1:0]          cmd_sub;
    logic [`QMM_AW-1:0]            cmd_addr;
    logic [`QMM_SUBS-1:0]          x_we;
    logic [`QMM_DW-1:0]            x_data;
    logic [`QMM_DW-1:0]            wb_dat;
    logic                          wb_ack;
    logic                          wb_cyc;
    logic                          wb_stb;
    logic [`QMM_AW-1:0]            wb_adr;
    logic                          fetch_done;
    logic [`QMM_SUBS-1:0]          exec_done;
    logic [`QMM_SUBS*`QMM_YW-1:0]  y_data;

    int err_cnt;
    int test_cnt;
    int test_fail;
    int err_mark;

    // What each sub-unit should hold
    logic [`QMM_DW-1:0]           pw_m   [`QMM_SUBS];
    logic [`QMM_ROWS*`QMM_DW-1:0] rows_m [`QMM_SUBS];
    logic [`QMM_DW-1:0]           x_m    [`QMM_SUBS];

    qmm_top u_qmm_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_cmd_valid  (cmd_valid),
        .i_cmd_op     (cmd_op),
        .i_cmd_sub    (cmd_sub),
        .i_cmd_addr   (cmd_addr),
        .i_x_we       (x_we),
        .i_x_data     (x_data),
        .i_wb_dat     (wb_dat),
        .i_wb_ack     (wb_ack),
        .o_wb_cyc     (wb_cyc),
        .o_wb_stb     (wb_stb),
        .o_wb_adr     (wb_adr),
        .o_fetch_done (fetch_done),
        .o_exec_done  (exec_done),
        .o_y_data     (y_data)
    );

    qmm_wb_mem u_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_wb_cyc (wb_cyc),
        .i_wb_stb (wb_stb),
        .i_wb_adr (wb_adr),
        .o_wb_dat (wb_dat),
        .o_wb_ack (wb_ack)
    );

    always #5 clk = ~clk;

    // Expected output bus from the vector and the parameter block
    function automatic logic [`QMM_YW-1:0] ref_y(input logic [`QMM_DW-1:0] x,
                                                 input logic [`QMM_DW-1:0] pw,
                                                 input logic [`QMM_ROWS*`QMM_DW-1:0] rows);
        logic [`QMM_YW-1:0] y;
        longint             acc;
        int                 zx;
        int                 zw;
        int                 xv;
        int                 wv;
        y  = '0;
        zx = int'($signed(pw[15:8]));
        zw = int'($signed(pw[7:4]));      // Four-bit signed weight zero point
        for (int r = 0; r < `QMM_ROWS; r++) begin
            acc = 0;
            for (int l = 0; l < `QMM_LANES; l++) begin
                xv  = int'($signed(x[l*8 +: 8]));
                wv  = int'($signed(rows[r*`QMM_DW + l*8 +: 8]));
                acc = acc + longint'((xv - zx) * (wv - zw));
            end
            acc = ((acc * longint'(pw[31:16])) >>> `QMM_SHIFT) + longint'(pw[3:0]);
            if (acc < 0) begin
                y[r*8 +: 8] = 8'd0;
            end else if (acc > 255) begin
                y[r*8 +: 8] = 8'd255;
            end else begin
                y[r*8 +: 8] = acc[7:0];
            end
        end
        return y;
    endfunction

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s expected %0h got %0h", $time, name, exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        err_cnt++;
        $display("%0t %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == err_mark) begin
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            test_fail++;
            $display("test %0d %s: FAILED", test_cnt, name);
        end
        err_mark = err_cnt;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic random_block(output logic [`QMM_DW-1:0] pw,
                                output logic [`QMM_ROWS*`QMM_DW-1:0] rows);
        pw = {16'(1 + $urandom % 32), 8'($urandom), 4'($urandom), 4'($urandom)};
        for (int r = 0; r < `QMM_ROWS; r++) begin
            rows[r*`QMM_DW +: `QMM_DW] = $urandom;
        end
    endtask

    task automatic load_x(input logic [`QMM_SUBW-1:0] sub, input logic [`QMM_DW-1:0] x);
        x_m[sub]  = x;
        x_data    = x;
        x_we[sub] = 1'b1;
        next_cycle();
        x_we      = '0;
    endtask

    // Preload the memory model, then fetch the block into one sub-unit
    task automatic run_fetch(input logic [`QMM_SUBW-1:0] sub, input logic [`QMM_AW-1:0] addr,
                             input logic [`QMM_DW-1:0] pw,
                             input logic [`QMM_ROWS*`QMM_DW-1:0] rows);
        int         base;
        int         drops;
        int         n;
        logic [5:0] idx;
        u_mem.mem[addr] = pw;
        for (int r = 0; r < `QMM_ROWS; r++) begin
            u_mem.mem[addr + 1 + r] = rows[r*`QMM_DW +: `QMM_DW];
        end
        pw_m[sub]   = pw;
        rows_m[sub] = rows;
        base        = u_mem.acc_cnt;
        drops       = u_mem.stb_err;
        cmd_valid   = 1'b1;
        cmd_op      = OP_FETCH;
        cmd_sub     = sub;
        cmd_addr    = addr;
        next_cycle();
        cmd_valid   = 1'b0;
        n = 0;
        while (!fetch_done && n < FETCH_TMO) begin
            next_cycle();
            n++;
        end
        if (!fetch_done) begin
            report_problem("The fetch did not signal done before its timeout");
        end else begin
            next_cycle();
            check("o_fetch_done after pulse", 0, fetch_done);
        end
        check("wishbone read count", `QMM_ROWS + 1, u_mem.acc_cnt - base);
        for (int i = 0; i <= `QMM_ROWS; i++) begin
            idx = 6'(base + i);
            check("o_wb_adr", addr + i, u_mem.acc_log[idx]);
        end
        check("stb dropped before ack", drops, u_mem.stb_err);
    endtask

    task automatic run_exec(input logic [`QMM_SUBW-1:0] sub);
        int n;
        cmd_valid = 1'b1;
        cmd_op    = OP_EXEC;
        cmd_sub   = sub;
        cmd_addr  = '0;
        next_cycle();                     // Command edge just passed
        cmd_valid = 1'b0;
        n = 0;
        while (!exec_done[sub] && n < EXEC_TMO) begin
            next_cycle();
            n++;
        end
        if (!exec_done[sub]) begin
            report_problem("The execute command did not signal done before its timeout");
        end else begin
            check("o_exec_done latency", LAT, n);
            check("o_y_data", ref_y(x_m[sub], pw_m[sub], rows_m[sub]),
                  y_data[sub*`QMM_YW +: `QMM_YW]);
        end
    endtask

    initial begin
        logic [`QMM_DW-1:0]           pw;
        logic [`QMM_ROWS*`QMM_DW-1:0] rows;
        logic [`QMM_YW-1:0]           y0;
        logic [`QMM_YW-1:0]           y1;
        int                           n;
        int                           seen0;
        int                           seen1;
        void'($urandom(SEED));
        err_cnt   = 0;
        test_cnt  = 0;
        test_fail = 0;
        err_mark  = 0;
        clk       = 1'b0;
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd_op    = OP_FETCH;
        cmd_sub   = '0;
        cmd_addr  = '0;
        x_we      = '0;
        x_data    = '0;
        repeat (RST_CYCLES) next_cycle();
        rst_n = 1'b1;
        next_cycle();

        check("o_wb_cyc", 0, wb_cyc);
        check("o_wb_stb", 0, wb_stb);
        check("o_fetch_done", 0, fetch_done);
        check("o_exec_done", 0, exec_done);
        check("o_y_data", 0, y_data);
        end_test("reset values");

        random_block(pw, rows);
        run_fetch(1, BLK_C, pw, rows);
        end_test("wishbone fetch sequence");

        random_block(pw, rows);
        run_fetch(0, BLK_A, pw, rows);
        load_x(0, $urandom);
        run_exec(0);
        end_test("fetch and execute on sub-unit 0");

        random_block(pw, rows);
        run_fetch(0, BLK_B, pw, rows);
        random_block(pw, rows);
        run_fetch(1, BLK_C, pw, rows);
        load_x(0, $urandom);
        load_x(1, $urandom);
        cmd_valid = 1'b1;
        cmd_op    = OP_EXEC;
        cmd_sub   = 0;
        next_cycle();
        cmd_sub   = 1;                    // Second command on the next edge
        next_cycle();
        cmd_valid = 1'b0;
        n     = 1;
        seen0 = -1;
        seen1 = -1;
        while (n < EXEC_TMO) begin
            if (exec_done[0] && seen0 < 0) begin
                seen0 = n;
                y0    = y_data[0 +: `QMM_YW];
            end
            if (exec_done[1] && seen1 < 0) begin
                seen1 = n;
                y1    = y_data[`QMM_YW +: `QMM_YW];
            end
            if (seen0 >= 0 && seen1 >= 0) begin
                break;
            end
            next_cycle();
            n++;
        end
        if (seen0 < 0 || seen1 < 0) begin
            report_problem("Both sub-units did not signal done before the timeout");
        end else begin
            check("o_exec_done[0] latency", LAT, seen0);
            check("o_exec_done[1] latency", LAT + 1, seen1);
            check("o_y_data sub 0", ref_y(x_m[0], pw_m[0], rows_m[0]), y0);
            check("o_y_data sub 1", ref_y(x_m[1], pw_m[1], rows_m[1]), y1);
        end
        end_test("independent sub-units");

        y1 = y_data[`QMM_YW +: `QMM_YW];
        load_x(0, $urandom);
        run_exec(0);
        check("o_y_data sub 1 held", y1, y_data[`QMM_YW +: `QMM_YW]);
        end_test("new vector with kept parameters");

        // Large scale, x minus zx at its maximum, extreme weights
        pw = {16'hffff, 8'h80, 4'h0, 4'h5};
        rows = {32'($urandom), 32'h0000_0000, 32'h7f7f_7f7f, 32'h8080_8080};
        run_fetch(1, BLK_SAT, pw, rows);
        load_x(1, 32'h7f7f_7f7f);
        run_exec(1);
        check("o_y_data row 0 low clamp", 8'd0, y_data[`QMM_YW +: 8]);
        check("o_y_data row 1 high clamp", 8'd255, y_data[`QMM_YW + 8 +: 8]);
        end_test("saturation");

        $display("tests %0d, failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+logic
logic/qmm_pkg.sv
logic/qmm_fetch.sv
logic/qmm_weight_store.sv
logic/qmm_operand_regs.sv
logic/qmm_exec.sv
logic/qmm_top.sv
bench/qmm_wb_mem.sv
bench/qmm_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --timescale 1ns/100ps --top-module qmm_tb -f compile.f -o qmm_sim \
    && ./obj_dir/qmm_sim | tee /dev/stderr | grep "Regression passed" > /dev/null \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }
